// File: colmix_bus_pkg.sv
package colmix_bus_pkg;

    // bus word address width
    localparam int BUS_AW = 12;

    // address regions, top two bits of the word address
    localparam logic [1:0] REG_CTRL = 2'd0;
    localparam logic [1:0] REG_PAL  = 2'd1;
    localparam logic [1:0] REG_PRIO = 2'd2;
    // region 3 left unmapped

    // requests from the cpu side
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [BUS_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // same word address, palette or table decoding
    typedef union packed {
        struct packed {
            logic [1:0] region;
            // which layer's palette bank
            logic [1:0] layer;
            logic [7:0] pen;
        } pal;
        struct packed {
            logic [1:0] region;
            logic [9:0] idx;
        } tbl;
    } bus_addr_u;

    // priority table access, one entry per strobe
    typedef struct packed {
        logic       we;
        logic [9:0] addr;
        logic [1:0] data;
    } tbl_wr_t;

    // palette access, data packed as red, green, blue
    typedef struct packed {
        logic        we;
        logic        re;
        logic [9:0]  addr;
        logic [23:0] data;
    } pal_wr_t;

endpackage

// File: colmix_video_pkg.sv
package colmix_video_pkg;

    // strobes from pixel in to colour out
    localparam int PIPE_DLY = 3;

    // palette is 4 banks of 256 colours
    localparam int PAL_AW = 10;

    // priority table is addressed by the flag word
    localparam int TBL_AW = 10;

    // one layer pixel
    // raw is the palette index, fld splits out the flag bits
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            // priority bit of the tile or sprite
            logic       pri;
            // colour group, only used as part of the index
            logic [2:0] mid;
            // pen 0 is transparent on most layers
            logic [3:0] pen;
        } fld;
    } pixel_u;

    // all four layers of the same screen position
    typedef struct packed {
        pixel_u ba0;
        pixel_u obj;
        pixel_u ba1;
        pixel_u ba2;
    } layer_pixels_t;

    // visible layer as stored in the priority table
    // also the top two bits of the palette address
    typedef enum logic [1:0] {
        BA0 = 2'd0,
        OBJ = 2'd1,
        BA1 = 2'd2,
        BA2 = 2'd3
    } layer_e;

    // colour word, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

// File: colmix_apb_port.sv
`timescale 1ns/100ps

module colmix_apb_port
    import colmix_bus_pkg::*, colmix_video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   req,
    output apb_rsp_t   rsp,
    output tbl_wr_t    tbl_wr,
    output pal_wr_t    pal_wr,
    input  logic [1:0] tbl_q,
    input  rgb_t       pal_q,
    output logic [2:0] prio_mode
);

    bus_addr_u addr;

    logic setup;
    logic access;
    logic map_ctrl;
    logic map_pal;
    logic map_tbl;
    logic unmapped;
    logic rd_mem;

    // control state
    logic rdy_q;
    logic err_q;
    logic tbl_we_q;
    logic pal_we_q;
    logic pal_re_q;
    logic ctrl_we_q;
    logic rd_en_q;

    // captured in the setup cycle, held to the end of the transfer
    logic [1:0]  rd_region_q;
    logic [9:0]  tbl_addr_q;
    logic [9:0]  pal_addr_q;
    logic [23:0] wdata_q;

    assign addr   = req.paddr;
    assign setup  = req.psel & ~req.penable;
    assign access = req.psel & req.penable;

    // only word 0 of the control region exists
    assign map_ctrl = (addr.tbl.region == REG_CTRL) && (addr.tbl.idx == '0);
    assign map_pal  = addr.pal.region == REG_PAL;
    assign map_tbl  = addr.tbl.region == REG_PRIO;
    assign unmapped = ~(map_ctrl | map_pal | map_tbl);

    // memory reads need one wait state
    assign rd_mem = ~req.pwrite & (map_pal | map_tbl);

    // decode in setup, strobes land in the first access cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_q     <= 1'b0;
            err_q     <= 1'b0;
            tbl_we_q  <= 1'b0;
            pal_we_q  <= 1'b0;
            pal_re_q  <= 1'b0;
            ctrl_we_q <= 1'b0;
            rd_en_q   <= 1'b0;
            prio_mode <= 3'd0;
        end else begin
            tbl_we_q  <= setup & req.pwrite & map_tbl;
            pal_we_q  <= setup & req.pwrite & map_pal;
            pal_re_q  <= setup & ~req.pwrite & map_pal;
            ctrl_we_q <= setup & req.pwrite & map_ctrl;
            err_q     <= setup & unmapped;
            // reads: low in first access, high in the second
            if (setup) begin
                rdy_q   <= ~rd_mem;
                rd_en_q <= ~req.pwrite & ~unmapped;
            end else begin
                rdy_q <= access & ~rdy_q;
            end
            if (ctrl_we_q) begin
                prio_mode <= wdata_q[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            rd_region_q <= addr.pal.region;
            tbl_addr_q  <= addr.tbl.idx;
            pal_addr_q  <= {addr.pal.layer, addr.pal.pen};
            wdata_q     <= req.pwdata[23:0];
        end
    end

    assign tbl_wr = '{we: tbl_we_q, addr: tbl_addr_q, data: wdata_q[1:0]};
    assign pal_wr = '{we: pal_we_q, re: pal_re_q, addr: pal_addr_q, data: wdata_q};

    // read data, zero for writes and errors
    always_comb begin
        rsp.pready  = rdy_q;
        rsp.pslverr = err_q;
        rsp.prdata  = '0;
        if (rd_en_q) begin
            case (rd_region_q)
                REG_CTRL: rsp.prdata = {29'd0, prio_mode};
                REG_PAL:  rsp.prdata = {8'd0, pal_q};
                REG_PRIO: rsp.prdata = {30'd0, tbl_q};
                default:  rsp.prdata = '0;
            endcase
        end
    end

    // registered pready relies on the master holding psel through access
    assert property (@(posedge clk) disable iff (rst)
        rsp.pready |-> (req.psel && req.penable))
        else $error("pready raised outside an access phase");

    assert property (@(posedge clk) disable iff (rst)
        !(tbl_wr.we && (pal_wr.we || pal_wr.re)))
        else $error("table and palette strobes overlap");

endmodule

// File: colmix_layer_sel.sv
`timescale 1ns/100ps

module colmix_layer_sel
    import colmix_bus_pkg::*, colmix_video_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  layer_pixels_t     pixels,
    input  logic [2:0]        prio_mode,
    input  tbl_wr_t           tbl_wr,
    output logic [1:0]        tbl_q,
    output logic [PAL_AW-1:0] pal_addr
);

    // priority table, one layer code per flag combination
    layer_e tbl_mem [1 << TBL_AW];

    logic [TBL_AW-1:0] flag_d;
    logic [TBL_AW-1:0] flag_q;
    layer_pixels_t     pix_s1;
    layer_pixels_t     pix_s2;
    layer_e            layer_q;
    pixel_u            pick;

    // flag word, mode in the top bits
    always_comb begin
        flag_d = {
            prio_mode,
            ~|pixels.ba0.fld.pen,
            pixels.obj.fld.pri,
            ~|pixels.obj.fld.pen,
            pixels.ba1.fld.pri,
            pixels.obj.fld.pen[3],
            ~|pixels.ba1.fld.pen[2:0],
            ~|{pixels.ba2.fld.pri, pixels.ba2.fld.pen[2:0]}
        };
    end

    // bus side of the table
    always_ff @(posedge clk) begin
        if (tbl_wr.we) begin
            tbl_mem[tbl_wr.addr] <= layer_e'(tbl_wr.data);
        end
        // address held by the bus port, so read every clock
        tbl_q <= tbl_mem[tbl_wr.addr];
    end

    // stage 1 flag address, stage 2 layer code
    // pixels follow two deep to stay aligned with the table output
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_q  <= '0;
            pix_s1  <= '0;
            pix_s2  <= '0;
            layer_q <= BA0;
        end else if (pxl_cen) begin
            flag_q  <= flag_d;
            pix_s1  <= pixels;
            layer_q <= tbl_mem[flag_q];
            pix_s2  <= pix_s1;
        end
    end

    // pick the winning layer's pixel
    always_comb begin
        case (layer_q)
            BA0:     pick = pix_s2.ba0;
            OBJ:     pick = pix_s2.obj;
            BA1:     pick = pix_s2.ba1;
            BA2:     pick = pix_s2.ba2;
            default: pick = pix_s2.ba0;
        endcase
    end

    // layer selects the palette bank
    assign pal_addr = {layer_q, pick.raw};

    // holds once the table is loaded before video starts
    assert property (@(posedge clk) disable iff (rst)
        !$isunknown(pal_addr))
        else $error("palette address has unknown bits");

endmodule

// File: colmix_palette.sv
`timescale 1ns/100ps

module colmix_palette
    import colmix_bus_pkg::*, colmix_video_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic              lhbl,
    input  logic              lvbl,
    input  logic [PAL_AW-1:0] pal_addr,
    input  pal_wr_t           pal_wr,
    output rgb_t              pal_q,
    output rgb_t              rgb,
    output logic              lhbl_dly,
    output logic              lvbl_dly
);

    // 4 banks x 256 colours
    rgb_t pal_mem [1 << PAL_AW];

    // colour read for the video side
    rgb_t col_q;

    // blank delay lines, oldest sample in the top bit
    logic [PIPE_DLY-1:0] hbl_sr;
    logic [PIPE_DLY-1:0] vbl_sr;

    // bus port, one entry per strobe
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_mem[pal_wr.addr] <= rgb_t'(pal_wr.data);
        end
        // read data valid the clock after re
        if (pal_wr.re) begin
            pal_q <= pal_mem[pal_wr.addr];
        end
    end

    // video port, stage 3
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            col_q <= pal_mem[pal_addr];
        end
    end

    // blanks go through the same number of strobes as the colour
    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[PIPE_DLY-2:0], lhbl};
            vbl_sr <= {vbl_sr[PIPE_DLY-2:0], lvbl};
        end
    end

    assign lhbl_dly = hbl_sr[PIPE_DLY-1];
    assign lvbl_dly = vbl_sr[PIPE_DLY-1];

    // black during either blank
    assign rgb = (lhbl_dly && lvbl_dly) ? col_q : '0;

    // bus port sends one direction per transfer
    assert property (@(posedge clk) disable iff (rst)
        !(pal_wr.re && pal_wr.we))
        else $error("palette read and write strobes together");

endmodule

// File: colmix_top.sv
`timescale 1ns/100ps

module colmix_top
    import colmix_bus_pkg::*, colmix_video_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  apb_req_t      apb_req,
    output apb_rsp_t      apb_rsp,
    input  logic          pxl_cen,
    input  logic          lhbl,
    input  logic          lvbl,
    input  layer_pixels_t pixels,
    output rgb_t          rgb,
    output logic          lhbl_dly,
    output logic          lvbl_dly
);

    // bus port to table and palette
    tbl_wr_t tbl_wr;
    pal_wr_t pal_wr;
    logic [1:0] tbl_q;
    rgb_t pal_q;
    logic [2:0] prio_mode;

    // selector to palette
    logic [PAL_AW-1:0] pal_addr;

    colmix_apb_port u_apb (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .req       ( apb_req   ),
        .rsp       ( apb_rsp   ),
        .tbl_wr    ( tbl_wr    ),
        .pal_wr    ( pal_wr    ),
        .tbl_q     ( tbl_q     ),
        .pal_q     ( pal_q     ),
        .prio_mode ( prio_mode )
    );

    colmix_layer_sel u_sel (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .pixels    ( pixels    ),
        .prio_mode ( prio_mode ),
        .tbl_wr    ( tbl_wr    ),
        .tbl_q     ( tbl_q     ),
        .pal_addr  ( pal_addr  )
    );

    colmix_palette u_pal (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .pal_addr  ( pal_addr  ),
        .pal_wr    ( pal_wr    ),
        .pal_q     ( pal_q     ),
        .rgb       ( rgb       ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  )
    );

endmodule

// File: tb_colmix.sv
`timescale 1ns/100ps

module tb_colmix
    import colmix_bus_pkg::*, colmix_video_pkg::*;
();

    // clocks allowed for pready before the transfer counts as hung
    localparam int APB_TIMEOUT = 16;
    localparam int RD_CHECKS   = 64;

    // one expected video output, colour already blanked
    typedef struct packed {
        logic [23:0] col;
        logic        hbl;
        logic        vbl;
    } exp_t;

    logic          clk;
    logic          rst;
    apb_req_t      apb_req;
    apb_rsp_t      apb_rsp;
    logic          pxl_cen;
    logic          lhbl;
    logic          lvbl;
    layer_pixels_t pixels;
    rgb_t          rgb;
    logic          lhbl_dly;
    logic          lvbl_dly;

    // shadow copies of the two RAMs and the mode register
    logic [23:0] pal_shadow [1024];
    logic [1:0]  tbl_shadow [1024];
    logic [2:0]  cur_mode;

    // outputs still in flight, oldest first
    exp_t exp_q [$];

    colmix_top UUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .apb_req  ( apb_req  ),
        .apb_rsp  ( apb_rsp  ),
        .pxl_cen  ( pxl_cen  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .pixels   ( pixels   ),
        .rgb      ( rgb      ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failed check");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch in %s: expected %h, actual %h", name, exp, act);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        stop_run();
    endtask

    // flag word from the pixel bytes, mode on top
    function automatic logic [9:0] priority_flags(input logic [2:0] mode,
        input logic [7:0] ba0, input logic [7:0] obj, input logic [7:0] ba1,
        input logic [7:0] ba2);
        return {mode, ba0[3:0] == 4'd0, obj[7], obj[3:0] == 4'd0, ba1[7], obj[3],
                ba1[2:0] == 3'd0, (ba2[7] == 1'b0) && (ba2[2:0] == 3'd0)};
    endfunction

    // setup, access, then wait states until pready
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        waits = 0;
        while (!apb_rsp.pready) begin
            if (waits >= APB_TIMEOUT) begin
                report_failure("pready did not rise within the APB timeout");
            end else begin
                waits++;
                @(negedge clk);
            end
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic bus_write(input string name, input logic [11:0] addr,
                             input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_xfer(1'b1, addr, data, rdata, err, waits);
        assert (err == exp_err) else report_mismatch({name, " pslverr"}, exp_err, err);
        assert (waits == 0) else report_mismatch({name, " wait states"}, 0, waits);
    endtask

    task automatic bus_read(input string name, input logic [11:0] addr,
                            input logic [31:0] exp_data, input logic exp_err,
                            input int exp_waits);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_xfer(1'b0, addr, 32'd0, rdata, err, waits);
        assert (err == exp_err) else report_mismatch({name, " pslverr"}, exp_err, err);
        assert (waits == exp_waits) else report_mismatch({name, " wait states"}, exp_waits, waits);
        assert (rdata == exp_data) else report_mismatch({name, " prdata"}, exp_data, rdata);
    endtask

    task automatic set_mode(input logic [2:0] mode);
        bus_write("mode write", 12'h000, {$urandom} & 32'hffff_fff8 | mode, 1'b0);
        cur_mode = mode;
        bus_read("mode read", 12'h000, {29'd0, mode}, 1'b0, 0);
    endtask

    // pixel strobed on the last rising edge enters the model
    task automatic account_strobe();
        logic [31:0] pix;
        logic [9:0]  flag;
        logic [1:0]  layer;
        logic [7:0]  pick;
        exp_t        e;
        if (pxl_cen) begin
            pix   = pixels;
            flag  = priority_flags(cur_mode, pix[31:24], pix[23:16], pix[15:8], pix[7:0]);
            layer = tbl_shadow[flag];
            case (layer)
                2'd0:    pick = pix[31:24];
                2'd1:    pick = pix[23:16];
                2'd2:    pick = pix[15:8];
                default: pick = pix[7:0];
            endcase
            e.col = (lhbl && lvbl) ? pal_shadow[{layer, pick}] : 24'd0;
            e.hbl = lhbl;
            e.vbl = lvbl;
            exp_q.push_back(e);
            // three strobes in flight, oldest now on the output
            if (exp_q.size() == PIPE_DLY) begin
                e = exp_q.pop_front();
                assert (rgb == e.col) else report_mismatch("video rgb", e.col, rgb);
                assert (lhbl_dly == e.hbl) else report_mismatch("lhbl_dly", e.hbl, lhbl_dly);
                assert (lvbl_dly == e.vbl) else report_mismatch("lvbl_dly", e.vbl, lvbl_dly);
            end
        end
    endtask

    task automatic run_video(input int n, input logic random_cen);
        repeat (n) begin
            @(negedge clk);
            account_strobe();
            pixels  = $urandom;
            pxl_cen = random_cen ? ($urandom_range(3) != 0) : 1'b1;
            // mostly active video
            lhbl    = $urandom_range(7) != 0;
            lvbl    = $urandom_range(15) != 0;
        end
        @(negedge clk);
        account_strobe();
        pxl_cen = 1'b0;
    endtask

    // black whenever either delayed blank is low
    assert property (@(posedge clk) disable iff (rst)
        (!lhbl_dly || !lvbl_dly) |-> (rgb == 24'd0))
        else report_failure("rgb not black during blanking");

    // no strobe, no change on the video outputs
    assert property (@(posedge clk) disable iff (rst)
        (!$past(pxl_cen) && !$past(rst)) |->
        ($stable(rgb) && $stable(lhbl_dly) && $stable(lvbl_dly)))
        else report_failure("video outputs moved without a pxl_cen strobe");

    // reset state of the bus and video outputs
    assert property (@(posedge clk)
        rst |=> (!apb_rsp.pready && !apb_rsp.pslverr && rgb == 24'd0 && !lhbl_dly && !lvbl_dly))
        else report_failure("outputs not cleared by reset");

    initial begin
        int          i;
        logic [9:0]  idx;
        logic [23:0] col;
        logic [1:0]  code;
        clk      = 1'b0;
        rst      = 1'b1;
        apb_req  = '0;
        pxl_cen  = 1'b0;
        lhbl     = 1'b0;
        lvbl     = 1'b0;
        pixels   = '0;
        cur_mode = 3'd0;
        void'($urandom(32'hf40c81ee));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // full palette and table load, video held off until done
        for (i = 0; i < 1024; i++) begin
            col = $urandom;
            pal_shadow[i] = col;
            bus_write("palette write", {2'b01, i[9:0]}, {$urandom} & 32'hff00_0000 | col, 1'b0);
        end
        for (i = 0; i < 1024; i++) begin
            code = $urandom_range(3);
            tbl_shadow[i] = code;
            bus_write("table write", {2'b10, i[9:0]}, {30'd0, code}, 1'b0);
        end

        // readback with one wait state
        for (i = 0; i < RD_CHECKS; i++) begin
            idx = $urandom_range(1023);
            bus_read("palette readback", {2'b01, idx}, {8'd0, pal_shadow[idx]}, 1'b0, 1);
            idx = $urandom_range(1023);
            bus_read("table readback", {2'b10, idx}, {30'd0, tbl_shadow[idx]}, 1'b0, 1);
        end

        // unmapped region and nonzero control words
        set_mode(3'($urandom_range(7)));
        idx = $urandom_range(1023);
        bus_write("region 3 write", {2'b11, idx}, $urandom, 1'b1);
        bus_read("palette after bad write", {2'b01, idx}, {8'd0, pal_shadow[idx]}, 1'b0, 1);
        bus_read("table after bad write", {2'b10, idx}, {30'd0, tbl_shadow[idx]}, 1'b0, 1);
        bus_read("region 3 read", {2'b11, idx}, 32'd0, 1'b1, 0);
        idx = $urandom_range(1023, 1);
        bus_write("control word write", {2'b00, idx}, $urandom, 1'b1);
        bus_read("control word read", {2'b00, idx}, 32'd0, 1'b1, 0);
        bus_read("mode after bad write", 12'h000, {29'd0, cur_mode}, 1'b0, 0);

        // steady strobes, then random strobes under new modes
        run_video(300, 1'b0);
        set_mode(3'($urandom_range(7)));
        run_video(300, 1'b1);
        set_mode(3'($urandom_range(7)));
        run_video(200, 1'b1);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: colmix.f
colmix_bus_pkg.sv
colmix_video_pkg.sv
colmix_apb_port.sv
colmix_layer_sel.sv
colmix_palette.sv
colmix_top.sv
tb_colmix.sv

// File: Bender.yml
package:
  name: colmix

sources:
  - files:
      - colmix_bus_pkg.sv
      - colmix_video_pkg.sv
      - colmix_apb_port.sv
      - colmix_layer_sel.sv
      - colmix_palette.sv
      - colmix_top.sv
  - target: test
    files:
      - tb_colmix.sv
